/* decoder_config.svh */
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// datapath and immediate width
`define XLEN 32

// register file has 32 entries
`define REG_ADDR_W 5

// beq bne blt bge bltu bgeu
`define BRANCH_MASK_W 6

// fixed register numbers used by the C2 forms
`define SP_REG 5'd2
`define RA_REG 5'd1

// word width, handed to the load/store stage for compressed ops
`define FUNC3_LW 3'b010

`endif

/* decoder_pkg.sv */
`default_nettype none

package decoder_pkg;

   // major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OPC_LOAD    = 5'b00000,
      OPC_MISCMEM = 5'b00011,
      OPC_OPIMM   = 5'b00100,
      OPC_AUIPC   = 5'b00101,
      OPC_STORE   = 5'b01000,
      OPC_OP      = 5'b01100,
      OPC_LUI     = 5'b01101,
      OPC_BRANCH  = 5'b11000,
      OPC_JALR    = 5'b11001,
      OPC_JAL     = 5'b11011,
      OPC_SYSTEM  = 5'b11100
   } opcode_e;

   // instr[1:0], FULL marks a 32-bit word
   typedef enum logic [1:0] {
      QUAD_C0   = 2'b00,
      QUAD_C1   = 2'b01,
      QUAD_C2   = 2'b10,
      QUAD_FULL = 2'b11
   } c_quadrant_e;

   // quadrant 2 funct3, instr[15:13]
   typedef enum logic [2:0] {
      C2_SLLI = 3'b000,
      C2_LWSP = 3'b010,
      C2_JR   = 3'b100, // also mv, add, jalr, ebreak
      C2_SWSP = 3'b110
   } c2_funct3_e;

   typedef enum logic [4:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_MUL,
      ALU_MULH,
      ALU_MULHSU,
      ALU_MULHU,
      ALU_DIV,
      ALU_DIVU,
      ALU_REM,
      ALU_REMU
   } alu_op_e;

   typedef enum logic {
      S1_REGVAL1 = 1'b0,
      S1_PC      = 1'b1
   } alu_s1_sel_e;

   typedef enum logic [1:0] {
      S2_REGVAL2 = 2'd0,
      S2_IMM     = 2'd1
   } alu_s2_sel_e;

   typedef enum logic [1:0] {
      RIN_ALU = 2'd0,
      RIN_IMM = 2'd1
   } reg_input_sel_e;

   // stage the execute FSM goes to next
   typedef enum logic [2:0] {
      NS_FETCH,
      NS_LOAD,
      NS_STORE,
      NS_BRANCH,
      NS_SYSTEM,
      NS_TRAP,
      NS_DEAD
   } next_stage_e;

   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'd0,
      F3_SLL     = 3'd1,
      F3_SLT     = 3'd2,
      F3_SLTU    = 3'd3,
      F3_XOR     = 3'd4,
      F3_SRL_SRA = 3'd5,
      F3_OR      = 3'd6,
      F3_AND     = 3'd7
   } funct3_e;

   typedef enum logic [6:0] {
      F7_DEFAULT = 7'b0000000,
      F7_ALT     = 7'b0100000, // sub, sra
      F7_MULDIV  = 7'b0000001
   } funct7_e;

endpackage

`default_nettype wire

/* base_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decoder_config.svh"

module base_decode (
   input  logic [`XLEN-1:0]          instr_i,
   output logic [`REG_ADDR_W-1:0]    rs1_o,
   output logic [`REG_ADDR_W-1:0]    rs2_o,
   output logic [`REG_ADDR_W-1:0]    rd_o,
   output logic [`XLEN-1:0]          imm_o,
   output logic [2:0]                funct3_o,
   output logic [`BRANCH_MASK_W-1:0] branch_mask_o,
   output decoder_pkg::alu_op_e        alu_op_o,
   output decoder_pkg::alu_s1_sel_e    alu_s1_sel_o,
   output decoder_pkg::alu_s2_sel_e    alu_s2_sel_o,
   output decoder_pkg::reg_input_sel_e reg_input_sel_o,
   output decoder_pkg::next_stage_e    next_stage_o,
   output logic                      writeback_from_alu_o,
   output logic                      writeback_from_imm_o,
   output logic                      next_pc_from_alu_o,
   output logic                      write_reg_o
);
   import decoder_pkg::*;

   opcode_e    opc;
   funct3_e    f3;
   logic [6:0] f7;

   assign opc = opcode_e'(instr_i[6:2]);
   assign f3  = funct3_e'(instr_i[14:12]);
   assign f7  = instr_i[31:25];

   assign rs1_o    = instr_i[19:15];
   assign rs2_o    = instr_i[24:20];
   assign rd_o     = instr_i[11:7];
   assign funct3_o = instr_i[14:12];

   always_comb begin
      case (opc)
         OPC_STORE:  imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]}; // s
         OPC_BRANCH: imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0}; // b, bit 0 always clear
         OPC_LUI,
         OPC_AUIPC:  imm_o = {instr_i[31:12], 12'b0}; // u
         OPC_JAL:    imm_o = {{(`XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0}; // j
         default:    imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]}; // i, junk for r-type
      endcase
   end

   // one-hot condition for the branch stage
   always_comb begin
      branch_mask_o = '0;
      if (opc == OPC_BRANCH) begin
         case (instr_i[14:12])
            3'b000:  branch_mask_o[0] = 1'b1; // beq
            3'b001:  branch_mask_o[1] = 1'b1; // bne
            3'b100:  branch_mask_o[2] = 1'b1; // blt
            3'b101:  branch_mask_o[3] = 1'b1; // bge
            3'b110:  branch_mask_o[4] = 1'b1; // bltu
            3'b111:  branch_mask_o[5] = 1'b1; // bgeu
            default: branch_mask_o    = '0;   // 010/011 reserved
         endcase
      end
   end

   always_comb begin
      alu_op_o             = ALU_ADD;
      alu_s1_sel_o         = S1_REGVAL1;
      alu_s2_sel_o         = S2_REGVAL2;
      reg_input_sel_o      = RIN_ALU;
      next_stage_o         = NS_FETCH;
      writeback_from_alu_o = 1'b0;
      writeback_from_imm_o = 1'b0;
      next_pc_from_alu_o   = 1'b0;
      write_reg_o          = 1'b0;
      case (opc)
         OPC_OP: begin
            writeback_from_alu_o = 1'b1; // result written back in fetch
            case (f3)
               F3_ADD_SUB: alu_op_o = (f7 == F7_MULDIV) ? ALU_MUL :
                                      (f7 == F7_ALT)    ? ALU_SUB : ALU_ADD;
               F3_SLL:     alu_op_o = (f7 == F7_MULDIV) ? ALU_MULH   : ALU_SLL;
               F3_SLT:     alu_op_o = (f7 == F7_MULDIV) ? ALU_MULHSU : ALU_SLT;
               F3_SLTU:    alu_op_o = (f7 == F7_MULDIV) ? ALU_MULHU  : ALU_SLTU;
               F3_XOR:     alu_op_o = (f7 == F7_MULDIV) ? ALU_DIV    : ALU_XOR;
               F3_SRL_SRA: alu_op_o = (f7 == F7_MULDIV) ? ALU_DIVU :
                                      (f7 == F7_ALT)    ? ALU_SRA  : ALU_SRL;
               F3_OR:      alu_op_o = (f7 == F7_MULDIV) ? ALU_REM    : ALU_OR;
               default:    alu_op_o = (f7 == F7_MULDIV) ? ALU_REMU   : ALU_AND;
            endcase
         end
         OPC_OPIMM: begin
            alu_s2_sel_o         = S2_IMM;
            writeback_from_alu_o = 1'b1;
            case (f3)
               F3_ADD_SUB: alu_op_o = ALU_ADD; // no subi
               F3_SLL:     alu_op_o = ALU_SLL;
               F3_SLT:     alu_op_o = ALU_SLT;
               F3_SLTU:    alu_op_o = ALU_SLTU;
               F3_XOR:     alu_op_o = ALU_XOR;
               F3_SRL_SRA: alu_op_o = f7[5] ? ALU_SRA : ALU_SRL; // srai carries bit 30
               F3_OR:      alu_op_o = ALU_OR;
               default:    alu_op_o = ALU_AND;
            endcase
         end
         OPC_LOAD: begin
            alu_s2_sel_o = S2_IMM; // address = rs1 + imm
            next_stage_o = NS_LOAD;
         end
         OPC_STORE: begin
            alu_s2_sel_o = S2_IMM;
            next_stage_o = NS_STORE;
         end
         OPC_JAL,
         OPC_JALR: begin
            write_reg_o        = 1'b1; // link address through the alu path
            alu_s1_sel_o       = opc[1] ? S1_PC : S1_REGVAL1; // bit 1 set only for jal
            alu_s2_sel_o       = S2_IMM;
            next_pc_from_alu_o = 1'b1;
         end
         OPC_BRANCH:  next_stage_o = NS_BRANCH; // compare rs1 against rs2
         OPC_AUIPC: begin
            alu_s1_sel_o         = S1_PC;
            alu_s2_sel_o         = S2_IMM;
            writeback_from_alu_o = 1'b1;
         end
         OPC_LUI: begin
            writeback_from_imm_o = 1'b1;
            reg_input_sel_o      = RIN_IMM;
         end
         OPC_MISCMEM: next_stage_o = NS_FETCH; // fence is a nop here
         OPC_SYSTEM:  next_stage_o = NS_SYSTEM;
         default:     next_stage_o = NS_TRAP;
      endcase
   end

endmodule

`default_nettype wire

/* compressed_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decoder_config.svh"

module compressed_decode (
   input  logic [`XLEN-1:0]            instr_i,
   output logic [`REG_ADDR_W-1:0]      rs1_o,
   output logic [`REG_ADDR_W-1:0]      rs2_o,
   output logic [`REG_ADDR_W-1:0]      rd_o,
   output logic [`XLEN-1:0]            imm_o,
   output logic [2:0]                  funct3_o,
   output decoder_pkg::alu_op_e        alu_op_o,
   output decoder_pkg::alu_s1_sel_e    alu_s1_sel_o,
   output decoder_pkg::alu_s2_sel_e    alu_s2_sel_o,
   output decoder_pkg::reg_input_sel_e reg_input_sel_o,
   output decoder_pkg::next_stage_e    next_stage_o,
   output logic                        writeback_from_alu_o,
   output logic                        writeback_from_imm_o,
   output logic                        next_pc_from_alu_o,
   output logic                        write_reg_o
);
   import decoder_pkg::*;

   c_quadrant_e quad;
   c2_funct3_e  c_f3;
   logic        rs1_zero;
   logic        rs2_zero;

   assign quad     = c_quadrant_e'(instr_i[1:0]);
   assign c_f3     = c2_funct3_e'(instr_i[15:13]);
   assign rs1_zero = (instr_i[11:7] == '0);
   assign rs2_zero = (instr_i[6:2] == '0);
   assign funct3_o = `FUNC3_LW; // all sp-relative accesses are words

   // zero-extended, only for the C2 forms kept here
   always_comb begin
      imm_o = '0;
      if (quad == QUAD_C2) begin
         case (c_f3)
            C2_SLLI: imm_o = {{(`XLEN-5){1'b0}}, instr_i[6:2]}; // shamt
            C2_LWSP: imm_o = {{(`XLEN-8){1'b0}}, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00};
            C2_SWSP: imm_o = {{(`XLEN-8){1'b0}}, instr_i[8:7], instr_i[12:9], 2'b00};
            default: imm_o = '0;
         endcase
      end
   end

   always_comb begin
      rs1_o                = instr_i[11:7];
      rs2_o                = instr_i[6:2];
      rd_o                 = instr_i[11:7];
      alu_op_o             = ALU_ADD;
      alu_s1_sel_o         = S1_REGVAL1;
      alu_s2_sel_o         = S2_REGVAL2;
      reg_input_sel_o      = RIN_ALU;
      next_stage_o         = NS_FETCH;
      writeback_from_alu_o = 1'b0;
      writeback_from_imm_o = 1'b0;
      next_pc_from_alu_o   = 1'b0;
      write_reg_o          = 1'b0;
      case (quad)
         QUAD_C1: next_stage_o = NS_FETCH; // treated as nop
         QUAD_C2: begin
            case (c_f3)
               C2_SLLI: begin
                  alu_op_o             = ALU_SLL;
                  alu_s2_sel_o         = S2_IMM;
                  writeback_from_alu_o = 1'b1;
                  if (instr_i[12]) next_stage_o = NS_DEAD; // shamt[5] illegal on rv32
               end
               C2_LWSP: begin
                  rs1_o        = `SP_REG;
                  alu_s2_sel_o = S2_IMM;
                  next_stage_o = rs1_zero ? NS_DEAD : NS_LOAD; // rd=0 reserved
               end
               C2_JR: begin
                  if (!instr_i[12]) begin
                     if (!rs2_zero) begin // c.mv, x0 + rs2
                        rs1_o                = '0;
                        writeback_from_alu_o = 1'b1;
                     end else if (rs1_zero) begin
                        next_stage_o = NS_DEAD; // c.jr with rs1=0 reserved
                     end else begin
                        next_pc_from_alu_o = 1'b1; // c.jr, rs1 + x0
                     end
                  end else if (!rs2_zero) begin
                     writeback_from_alu_o = !rs1_zero; // c.add, rd=0 is a hint
                  end else if (!rs1_zero) begin
                     rd_o               = `RA_REG; // c.jalr links to ra
                     write_reg_o        = 1'b1;
                     next_pc_from_alu_o = 1'b1;
                  end else begin
                     next_stage_o = NS_DEAD; // ebreak not handled
                  end
               end
               C2_SWSP: begin
                  rs1_o        = `SP_REG;
                  alu_s2_sel_o = S2_IMM;
                  next_stage_o = NS_STORE;
               end
               default: next_stage_o = NS_DEAD;
            endcase
         end
         default: next_stage_o = NS_DEAD; // quadrant 0 not supported
      endcase
   end

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decoder_config.svh"

module decoder (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        en_i,
   input  logic [`XLEN-1:0]            instr_i,
   output logic [`REG_ADDR_W-1:0]      rs1_o,
   output logic [`REG_ADDR_W-1:0]      rs2_o,
   output logic [`REG_ADDR_W-1:0]      rd_o,
   output logic [`XLEN-1:0]            imm_o,
   output logic [`BRANCH_MASK_W-1:0]   branch_mask_o,
   output decoder_pkg::alu_op_e        alu_op_o,
   output decoder_pkg::alu_s1_sel_e    alu_s1_sel_o,
   output decoder_pkg::alu_s2_sel_e    alu_s2_sel_o,
   output decoder_pkg::reg_input_sel_e reg_input_sel_o,
   output decoder_pkg::next_stage_e    next_stage_o,
   output logic                        writeback_from_alu_o,
   output logic                        writeback_from_imm_o,
   output logic                        next_pc_from_alu_o,
   output logic                        write_reg_o,
   output logic [2:0]                  funct3_o
);
   import decoder_pkg::*;

   logic                     full; // 32-bit encoding
   logic [`REG_ADDR_W-1:0]   b_rs1, b_rs2, b_rd, c_rs1, c_rs2, c_rd;
   logic [`XLEN-1:0]         b_imm, c_imm;
   logic [2:0]               b_f3, c_f3;
   logic [`BRANCH_MASK_W-1:0] b_mask;
   alu_op_e                  b_alu, c_alu;
   alu_s1_sel_e              b_s1, c_s1;
   alu_s2_sel_e              b_s2, c_s2;
   reg_input_sel_e           b_rin, c_rin;
   next_stage_e              b_ns, c_ns;
   logic                     b_wba, b_wbi, b_npc, b_wr;
   logic                     c_wba, c_wbi, c_npc, c_wr;

   assign full = (instr_i[1:0] == QUAD_FULL);

   base_decode base_decode_i (
      .instr_i(instr_i), .rs1_o(b_rs1), .rs2_o(b_rs2), .rd_o(b_rd), .imm_o(b_imm),
      .funct3_o(b_f3), .branch_mask_o(b_mask), .alu_op_o(b_alu), .alu_s1_sel_o(b_s1),
      .alu_s2_sel_o(b_s2), .reg_input_sel_o(b_rin), .next_stage_o(b_ns),
      .writeback_from_alu_o(b_wba), .writeback_from_imm_o(b_wbi),
      .next_pc_from_alu_o(b_npc), .write_reg_o(b_wr)
   );

   compressed_decode compressed_decode_i (
      .instr_i(instr_i), .rs1_o(c_rs1), .rs2_o(c_rs2), .rd_o(c_rd), .imm_o(c_imm),
      .funct3_o(c_f3), .alu_op_o(c_alu), .alu_s1_sel_o(c_s1),
      .alu_s2_sel_o(c_s2), .reg_input_sel_o(c_rin), .next_stage_o(c_ns),
      .writeback_from_alu_o(c_wba), .writeback_from_imm_o(c_wbi),
      .next_pc_from_alu_o(c_npc), .write_reg_o(c_wr)
   );

   // sources stay combinational so the register file reads during decode
   assign rs1_o = full ? b_rs1 : c_rs1;
   assign rs2_o = full ? b_rs2 : c_rs2;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_o                 <= '0;
         imm_o                <= '0;
         funct3_o             <= '0;
         branch_mask_o        <= '0;
         alu_op_o             <= ALU_ADD;
         alu_s1_sel_o         <= S1_REGVAL1;
         alu_s2_sel_o         <= S2_REGVAL2;
         reg_input_sel_o      <= RIN_ALU;
         next_stage_o         <= NS_FETCH;
         writeback_from_alu_o <= 1'b0;
         writeback_from_imm_o <= 1'b0;
         next_pc_from_alu_o   <= 1'b0;
         write_reg_o          <= 1'b0;
      end else if (en_i) begin // hold while the stage is stalled
         rd_o                 <= full ? b_rd  : c_rd;
         imm_o                <= full ? b_imm : c_imm;
         funct3_o             <= full ? b_f3  : c_f3;
         branch_mask_o        <= full ? b_mask : '0; // no compressed branches
         alu_op_o             <= full ? b_alu : c_alu;
         alu_s1_sel_o         <= full ? b_s1  : c_s1;
         alu_s2_sel_o         <= full ? b_s2  : c_s2;
         reg_input_sel_o      <= full ? b_rin : c_rin;
         next_stage_o         <= full ? b_ns  : c_ns;
         writeback_from_alu_o <= full ? b_wba : c_wba;
         writeback_from_imm_o <= full ? b_wbi : c_wbi;
         next_pc_from_alu_o   <= full ? b_npc : c_npc;
         write_reg_o          <= full ? b_wr  : c_wr;
      end
   end

endmodule

`default_nettype wire

/* tb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "decoder_config.svh"

module tb_decoder;
   import decoder_pkg::*;

   logic                        clk_i;
   logic                        reset_i;
   logic                        en_i;
   logic [`XLEN-1:0]            instr_i;
   logic [`REG_ADDR_W-1:0]      rs1_o, rs2_o, rd_o;
   logic [`XLEN-1:0]            imm_o;
   logic [`BRANCH_MASK_W-1:0]   branch_mask_o;
   alu_op_e                     alu_op_o;
   alu_s1_sel_e                 alu_s1_sel_o;
   alu_s2_sel_e                 alu_s2_sel_o;
   reg_input_sel_e              reg_input_sel_o;
   next_stage_e                 next_stage_o;
   logic                        writeback_from_alu_o, writeback_from_imm_o;
   logic                        next_pc_from_alu_o, write_reg_o;
   logic [2:0]                  funct3_o;

   logic [31:0] lfsr;
   // expected outputs from the reference model
   logic [4:0]  e_rs1, e_rs2, e_rd, e_alu;
   logic [31:0] e_imm;
   logic [2:0]  e_f3, e_ns;
   logic [5:0]  e_mask;
   logic        e_s1, e_wba, e_wbi, e_npc, e_wr;
   logic [1:0]  e_s2, e_rin;

   decoder decoder_i (
      .clk_i(clk_i), .reset_i(reset_i), .en_i(en_i), .instr_i(instr_i),
      .rs1_o(rs1_o), .rs2_o(rs2_o), .rd_o(rd_o), .imm_o(imm_o),
      .branch_mask_o(branch_mask_o), .alu_op_o(alu_op_o), .alu_s1_sel_o(alu_s1_sel_o),
      .alu_s2_sel_o(alu_s2_sel_o), .reg_input_sel_o(reg_input_sel_o),
      .next_stage_o(next_stage_o), .writeback_from_alu_o(writeback_from_alu_o),
      .writeback_from_imm_o(writeback_from_imm_o),
      .next_pc_from_alu_o(next_pc_from_alu_o), .write_reg_o(write_reg_o),
      .funct3_o(funct3_o)
   );

   always #50 clk_i = ~clk_i; // 100 ns period

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr); // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   // expected fields, immediate and control word for 32-bit words
   task automatic predict_base(input logic [31:0] w);
      logic [4:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      opc   = w[6:2];
      f3    = w[14:12];
      f7    = w[31:25];
      e_rs1 = w[19:15];
      e_rs2 = w[24:20];
      e_rd  = w[11:7];
      e_f3  = f3;
      case (opc)
         5'b01000: e_imm = {{20{w[31]}}, w[31:25], w[11:7]};
         5'b11000: e_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         5'b01101, 5'b00101: e_imm = {w[31:12], 12'b0};
         5'b11011: e_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         default: e_imm = {{20{w[31]}}, w[31:20]};
      endcase
      e_mask = '0;
      if (opc == 5'b11000) begin
         case (f3)
            3'd0: e_mask = 6'b000001;
            3'd1: e_mask = 6'b000010;
            3'd4: e_mask = 6'b000100;
            3'd5: e_mask = 6'b001000;
            3'd6: e_mask = 6'b010000;
            3'd7: e_mask = 6'b100000;
            default: e_mask = '0;
         endcase
      end
      case (opc)
         5'b01100: begin // register-register ops with M mapping on funct7 1
            e_wba = 1'b1;
            if (f7 == 7'h01) begin
               case (f3)
                  3'd0: e_alu = ALU_MUL;
                  3'd1: e_alu = ALU_MULH;
                  3'd2: e_alu = ALU_MULHSU;
                  3'd3: e_alu = ALU_MULHU;
                  3'd4: e_alu = ALU_DIV;
                  3'd5: e_alu = ALU_DIVU;
                  3'd6: e_alu = ALU_REM;
                  default: e_alu = ALU_REMU;
               endcase
            end else begin
               case (f3)
                  3'd0: e_alu = (f7 == 7'h20) ? ALU_SUB : ALU_ADD;
                  3'd1: e_alu = ALU_SLL;
                  3'd2: e_alu = ALU_SLT;
                  3'd3: e_alu = ALU_SLTU;
                  3'd4: e_alu = ALU_XOR;
                  3'd5: e_alu = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
                  3'd6: e_alu = ALU_OR;
                  default: e_alu = ALU_AND;
               endcase
            end
         end
         5'b00100: begin
            e_s2  = S2_IMM;
            e_wba = 1'b1;
            case (f3)
               3'd0: e_alu = ALU_ADD;
               3'd1: e_alu = ALU_SLL;
               3'd2: e_alu = ALU_SLT;
               3'd3: e_alu = ALU_SLTU;
               3'd4: e_alu = ALU_XOR;
               3'd5: e_alu = w[30] ? ALU_SRA : ALU_SRL;
               3'd6: e_alu = ALU_OR;
               default: e_alu = ALU_AND;
            endcase
         end
         5'b00000: begin
            e_s2 = S2_IMM;
            e_ns = NS_LOAD;
         end
         5'b01000: begin
            e_s2 = S2_IMM;
            e_ns = NS_STORE;
         end
         5'b11011, 5'b11001: begin
            e_wr  = 1'b1;
            e_s1  = (opc == 5'b11011) ? S1_PC : S1_REGVAL1;
            e_s2  = S2_IMM;
            e_npc = 1'b1;
         end
         5'b11000: e_ns = NS_BRANCH;
         5'b00101: begin
            e_s1  = S1_PC;
            e_s2  = S2_IMM;
            e_wba = 1'b1;
         end
         5'b01101: begin
            e_wbi = 1'b1;
            e_rin = RIN_IMM;
         end
         5'b00011: e_ns = NS_FETCH;
         5'b11100: e_ns = NS_SYSTEM;
         default:  e_ns = NS_TRAP;
      endcase
   endtask

   task automatic predict_compressed(input logic [31:0] w);
      logic [4:0] r1;
      logic [4:0] r2;
      r1    = w[11:7];
      r2    = w[6:2];
      e_rs1 = r1;
      e_rs2 = r2;
      e_rd  = r1;
      e_f3  = 3'b010; // word access
      e_imm = '0;
      e_mask = '0;
      if (w[1:0] == 2'b00) begin
         e_ns = NS_DEAD;
      end else if (w[1:0] == 2'b10) begin
         case (w[15:13])
            3'd0: begin // c.slli
               e_imm = {27'b0, w[6:2]};
               e_alu = ALU_SLL;
               e_s2  = S2_IMM;
               e_wba = 1'b1;
               if (w[12]) e_ns = NS_DEAD;
            end
            3'd2: begin // c.lwsp
               e_rs1 = 5'd2;
               e_imm = {24'b0, w[3:2], w[12], w[6:4], 2'b00};
               e_s2  = S2_IMM;
               e_ns  = (r1 == 5'd0) ? NS_DEAD : NS_LOAD;
            end
            3'd6: begin // c.swsp
               e_rs1 = 5'd2;
               e_imm = {24'b0, w[8:7], w[12:9], 2'b00};
               e_s2  = S2_IMM;
               e_ns  = NS_STORE;
            end
            3'd4: begin
               if (!w[12] && r2 != 5'd0) begin // c.mv
                  e_rs1 = 5'd0;
                  e_wba = 1'b1;
               end else if (!w[12] && r1 == 5'd0) begin
                  e_ns = NS_DEAD;
               end else if (!w[12]) begin
                  e_npc = 1'b1; // c.jr
               end else if (r2 != 5'd0) begin
                  e_wba = (r1 != 5'd0); // c.add with x0 target is a hint
               end else if (r1 != 5'd0) begin
                  e_rd  = 5'd1; // c.jalr
                  e_wr  = 1'b1;
                  e_npc = 1'b1;
               end else begin
                  e_ns = NS_DEAD; // c.ebreak
               end
            end
            default: e_ns = NS_DEAD;
         endcase
      end
   endtask

   task automatic predict(input logic [31:0] w);
      e_alu = ALU_ADD;
      e_s1  = S1_REGVAL1;
      e_s2  = S2_REGVAL2;
      e_rin = RIN_ALU;
      e_ns  = NS_FETCH;
      e_wba = 1'b0;
      e_wbi = 1'b0;
      e_npc = 1'b0;
      e_wr  = 1'b0;
      if (w[1:0] == 2'b11) predict_base(w);
      else predict_compressed(w);
   endtask

   task automatic check_registered();
      check_field("rd_o", 32'(rd_o), 32'(e_rd));
      check_field("imm_o", imm_o, e_imm);
      check_field("funct3_o", 32'(funct3_o), 32'(e_f3));
      check_field("branch_mask_o", 32'(branch_mask_o), 32'(e_mask));
      check_field("alu_op_o", 32'(alu_op_o), 32'(e_alu));
      check_field("alu_s1_sel_o", 32'(alu_s1_sel_o), 32'(e_s1));
      check_field("alu_s2_sel_o", 32'(alu_s2_sel_o), 32'(e_s2));
      check_field("reg_input_sel_o", 32'(reg_input_sel_o), 32'(e_rin));
      check_field("next_stage_o", 32'(next_stage_o), 32'(e_ns));
      check_field("writeback_from_alu_o", 32'(writeback_from_alu_o), 32'(e_wba));
      check_field("writeback_from_imm_o", 32'(writeback_from_imm_o), 32'(e_wbi));
      check_field("next_pc_from_alu_o", 32'(next_pc_from_alu_o), 32'(e_npc));
      check_field("write_reg_o", 32'(write_reg_o), 32'(e_wr));
   endtask

   // load w on an enabled edge and offer junk with en low
   task automatic apply(input logic [31:0] w);
      logic [31:0] junk;
      take_bits(32, junk);
      @(posedge clk_i);
      instr_i <= w;
      en_i    <= 1'b1;
      @(negedge clk_i);
      predict(w);
      check_field("rs1_o", 32'(rs1_o), 32'(e_rs1)); // same-cycle source fields
      check_field("rs2_o", 32'(rs2_o), 32'(e_rs2));
      @(posedge clk_i);
      instr_i <= junk;
      en_i    <= 1'b0;
      @(negedge clk_i);
      predict(junk);
      check_field("rs1_o", 32'(rs1_o), 32'(e_rs1));
      check_field("rs2_o", 32'(rs2_o), 32'(e_rs2));
      predict(w);
      check_registered(); // loaded from w
      @(posedge clk_i); // junk clocked in with en low
      @(negedge clk_i);
      check_registered(); // still holding w
   endtask

   task automatic run_base(input logic [4:0] opc, input int count);
      logic [31:0] w;
      logic [31:0] k;
      for (int i = 0; i < count; i++) begin
         take_bits(32, w);
         w[6:0] = {opc, 2'b11};
         if (opc == 5'b01100) begin
            take_bits(2, k);
            w[31:25] = (k == 32'd0) ? 7'h00 : (k == 32'd1) ? 7'h20 : 7'h01;
         end
         apply(w);
      end
   endtask

   task automatic check_reset();
      e_rd = '0;
      e_imm = '0;
      e_f3 = '0;
      e_mask = '0;
      e_alu = ALU_ADD;
      e_s1 = S1_REGVAL1;
      e_s2 = S2_REGVAL2;
      e_rin = RIN_ALU;
      e_ns = NS_FETCH;
      e_wba = 1'b0;
      e_wbi = 1'b0;
      e_npc = 1'b0;
      e_wr = 1'b0;
      check_registered();
   endtask

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < 20000) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout: stimulus did not finish within %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $fatal(1);
   end

   initial begin
      logic [31:0] w;
      clk_i   = 1'b0;
      reset_i = 1'b1;
      en_i    = 1'b0;
      instr_i = '0;
      lfsr    = 32'hfd11_7cde;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      check_reset();
      @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i); // first edge with reset low and en low
      @(negedge clk_i);
      check_reset(); // still cleared with en low
      run_base(5'b01100, 60);
      run_base(5'b00100, 40);
      run_base(5'b00000, 10);
      run_base(5'b01000, 15);
      run_base(5'b11011, 15);
      run_base(5'b11001, 10);
      run_base(5'b11000, 30);
      run_base(5'b00101, 10);
      run_base(5'b01101, 10);
      run_base(5'b00011, 5);
      run_base(5'b11100, 5);
      run_base(5'b11111, 5); // undefined opcodes
      run_base(5'b01010, 5);
      apply(32'h0000_1002); // c.slli with bit 12 set
      apply(32'h0000_4002); // c.lwsp to x0
      apply(32'h0000_8002); // c.jr x0
      apply(32'h0000_9002); // c.ebreak
      apply(32'h0000_9082); // c.jalr x1
      apply(32'h0000_0001); // quadrant 1
      apply(32'h0000_0000); // quadrant 0
      for (int i = 0; i < 150; i++) begin
         take_bits(32, w);
         w[1:0] = (i % 8 == 0) ? 2'b01 : (i % 8 == 1) ? 2'b00 : 2'b10;
         apply(w);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* decoder.f */
+incdir+.
decoder_pkg.sv
base_decode.sv
compressed_decode.sv
decoder.sv
tb_decoder.sv

/* run_sim.sh */
#!/bin/sh
# builds the decoder testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_decoder -f decoder.f -o tb_decoder
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_decoder > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   echo "run ended without a result, status $run_status"
   exit 1
fi
exit 0
